/* source/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // ------------------------------------------------------------
    // basic data types
    // ------------------------------------------------------------

    // one machine word, data or address
    typedef logic [31:0] word_t;
    // register number, r0..r31
    typedef logic [4:0] reg_addr_t;

    // alu operations of the kept subset
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_lui
    } alu_op_t;

    // ------------------------------------------------------------
    // instruction encodings
    // ------------------------------------------------------------

    // opcode field, inst[31:26]
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_xori    = 6'b001110;
    localparam logic [5:0] op_lui     = 6'b001111;

    // function field of special, inst[5:0]
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_nor  = 6'b100111;
    localparam logic [5:0] fn_slt  = 6'b101010;

    // boot rom address, kseg1
    localparam word_t reset_vector = 32'hbfc00000;

endpackage

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  mips_pkg::alu_op_t op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    output mips_pkg::word_t   result
);

    logic [4:0] sa;
    logic       less;

    // shift amount from low bits of a
    assign sa   = a[4:0];
    // signed compare for slt
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            mips_pkg::alu_add: result = a + b;
            mips_pkg::alu_sub: result = a - b;
            mips_pkg::alu_and: result = a & b;
            mips_pkg::alu_or:  result = a | b;
            mips_pkg::alu_xor: result = a ^ b;
            mips_pkg::alu_nor: result = ~(a | b);
            mips_pkg::alu_slt: result = {31'd0, less};
            mips_pkg::alu_sll: result = b << sa;
            mips_pkg::alu_srl: result = b >> sa;
            // immediate into the upper half
            mips_pkg::alu_lui: result = {b[15:0], 16'h0000};
            default:           result = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* source/inst_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  mips_pkg::word_t     inst,
    output mips_pkg::alu_op_t   alu_op,
    output logic                a_is_shamt,
    output logic                b_is_imm,
    output logic                imm_zero_ext,
    output logic                wen,
    output mips_pkg::reg_addr_t waddr
);

    logic [5:0]          opcode;
    logic [5:0]          funct;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    logic                known;
    logic                is_rtype;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];

    // ------------------------------------------------------------
    // opcode and function decode
    // ------------------------------------------------------------
    always_comb begin
        // unknown encodings fall out as a no-op
        alu_op       = mips_pkg::alu_add;
        a_is_shamt   = 1'b0;
        b_is_imm     = 1'b0;
        imm_zero_ext = 1'b0;
        known        = 1'b1;
        is_rtype     = 1'b0;
        case (opcode)
            mips_pkg::op_special: begin
                is_rtype = 1'b1;
                case (funct)
                    mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_xor:  alu_op = mips_pkg::alu_xor;
                    mips_pkg::fn_nor:  alu_op = mips_pkg::alu_nor;
                    mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
                    // shifts take sa in place of rs
                    mips_pkg::fn_sll: begin
                        alu_op     = mips_pkg::alu_sll;
                        a_is_shamt = 1'b1;
                    end
                    mips_pkg::fn_srl: begin
                        alu_op     = mips_pkg::alu_srl;
                        a_is_shamt = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            // addiu sign extends, the logic ops zero extend
            mips_pkg::op_addiu: b_is_imm = 1'b1;
            mips_pkg::op_andi: begin
                alu_op       = mips_pkg::alu_and;
                b_is_imm     = 1'b1;
                imm_zero_ext = 1'b1;
            end
            mips_pkg::op_ori: begin
                alu_op       = mips_pkg::alu_or;
                b_is_imm     = 1'b1;
                imm_zero_ext = 1'b1;
            end
            mips_pkg::op_xori: begin
                alu_op       = mips_pkg::alu_xor;
                b_is_imm     = 1'b1;
                imm_zero_ext = 1'b1;
            end
            mips_pkg::op_lui: begin
                alu_op       = mips_pkg::alu_lui;
                b_is_imm     = 1'b1;
                imm_zero_ext = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    // rd for r-type, rt for immediates
    assign waddr = is_rtype ? rd : rt;
    // r0 writes dropped here once for the whole core
    assign wen   = known && (waddr != 5'd0);

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                resetn,
    input  mips_pkg::reg_addr_t raddr1,
    input  mips_pkg::reg_addr_t raddr2,
    output mips_pkg::word_t     rdata1,
    output mips_pkg::word_t     rdata2,
    input  logic                wen,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata
);

    mips_pkg::word_t regs [32];

    // write at the end of the write-back cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            // r0 stays zero, wen never points at it
            regs[0] <= '0;
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational read, same-cycle write comes in via bypass
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

/* source/operand_bypass.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_bypass (
    input  mips_pkg::reg_addr_t raddr,
    input  mips_pkg::word_t     rf_data,
    // instruction now in execute
    input  logic                ex_wen,
    input  mips_pkg::reg_addr_t ex_waddr,
    input  mips_pkg::word_t     ex_result,
    // instruction now in write-back
    input  logic                wb_wen,
    input  mips_pkg::reg_addr_t wb_waddr,
    input  mips_pkg::word_t     wb_wdata,
    output mips_pkg::word_t     operand
);

    logic hit_ex;
    logic hit_wb;

    // bubbles carry wen low, so no valid term needed
    assign hit_ex = ex_wen && (ex_waddr == raddr);
    assign hit_wb = wb_wen && (wb_waddr == raddr);

    // newest producer wins
    always_comb begin
        if (hit_ex) begin
            operand = ex_result;
        end else if (hit_wb) begin
            operand = wb_wdata;
        end else begin
            operand = rf_data;
        end
    end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter mips_pkg::word_t reset_pc = mips_pkg::reset_vector
) (
    input  logic            clk,
    input  logic            resetn,
    // instruction port, sram-like
    output logic            inst_req,
    output mips_pkg::word_t inst_addr,
    input  logic            inst_addr_ok,
    input  logic            inst_data_ok,
    input  mips_pkg::word_t inst_rdata,
    // to decode
    output logic            fd_valid,
    output mips_pkg::word_t fd_inst,
    output mips_pkg::word_t fd_pc
);

    // fetch states
    typedef enum logic [1:0] {
        st_reset,
        st_request,
        st_wait_data
    } fetch_state_t;

    fetch_state_t    state;
    mips_pkg::word_t pc;
    logic            data_done;

    // word comes back this edge
    assign data_done = (state == st_wait_data) && inst_data_ok;

    // request held until addr_ok, address is the pc itself
    assign inst_req  = (state == st_request);
    assign inst_addr = pc;

    // ------------------------------------------------------------
    // state machine and pc
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= st_reset;
            pc       <= reset_pc;
            fd_valid <= 1'b0;
        end else begin
            // one pulse per returned word
            fd_valid <= data_done;
            case (state)
                // one idle cycle out of reset
                st_reset: state <= st_request;
                st_request: begin
                    if (inst_addr_ok) begin
                        state <= st_wait_data;
                    end
                end
                st_wait_data: begin
                    if (inst_data_ok) begin
                        state <= st_request;
                        pc    <= pc + 32'd4;
                    end
                end
                default: state <= st_reset;
            endcase
        end
    end

    // fetch-to-decode payload, word paired with its address
    always_ff @(posedge clk) begin
        if (data_done) begin
            fd_inst <= inst_rdata;
            fd_pc   <= pc;
        end
    end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                resetn,
    // from fetch
    input  logic                fd_valid,
    input  mips_pkg::word_t     fd_inst,
    input  mips_pkg::word_t     fd_pc,
    // decode-to-execute register
    output logic                de_valid,
    output mips_pkg::word_t     de_pc,
    output mips_pkg::alu_op_t   de_alu_op,
    output mips_pkg::word_t     de_a,
    output mips_pkg::word_t     de_b,
    output logic                de_wen,
    output mips_pkg::reg_addr_t de_waddr,
    // bypass sources
    input  logic                ex_wen,
    input  mips_pkg::reg_addr_t ex_waddr,
    input  mips_pkg::word_t     ex_result,
    input  logic                wb_wen,
    input  mips_pkg::reg_addr_t wb_waddr,
    input  mips_pkg::word_t     wb_wdata
);

    mips_pkg::alu_op_t   alu_op;
    logic                a_is_shamt;
    logic                b_is_imm;
    logic                imm_zero_ext;
    logic                dec_wen;
    mips_pkg::reg_addr_t dec_waddr;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::word_t     rf_rdata1;
    mips_pkg::word_t     rf_rdata2;
    mips_pkg::word_t     rs_value;
    mips_pkg::word_t     rt_value;
    mips_pkg::word_t     imm;
    mips_pkg::word_t     shamt;

    assign rs = fd_inst[25:21];
    assign rt = fd_inst[20:16];

    // ------------------------------------------------------------
    // decode and register read
    // ------------------------------------------------------------
    inst_decoder inst_decoder_inst (
        .inst         (fd_inst),
        .alu_op       (alu_op),
        .a_is_shamt   (a_is_shamt),
        .b_is_imm     (b_is_imm),
        .imm_zero_ext (imm_zero_ext),
        .wen          (dec_wen),
        .waddr        (dec_waddr)
    );

    // write port driven straight from write-back
    reg_file reg_file_inst (
        .clk    (clk),
        .resetn (resetn),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wen    (wb_wen),
        .waddr  (wb_waddr),
        .wdata  (wb_wdata)
    );

    // one bypass per source register
    operand_bypass bypass_rs_inst (
        .raddr     (rs),
        .rf_data   (rf_rdata1),
        .ex_wen    (ex_wen),
        .ex_waddr  (ex_waddr),
        .ex_result (ex_result),
        .wb_wen    (wb_wen),
        .wb_waddr  (wb_waddr),
        .wb_wdata  (wb_wdata),
        .operand   (rs_value)
    );

    operand_bypass bypass_rt_inst (
        .raddr     (rt),
        .rf_data   (rf_rdata2),
        .ex_wen    (ex_wen),
        .ex_waddr  (ex_waddr),
        .ex_result (ex_result),
        .wb_wen    (wb_wen),
        .wb_waddr  (wb_waddr),
        .wb_wdata  (wb_wdata),
        .operand   (rt_value)
    );

    // ------------------------------------------------------------
    // operand build
    // ------------------------------------------------------------
    // zero ext for andi/ori/xori/lui, sign ext for addiu
    assign imm   = imm_zero_ext ? {16'h0000, fd_inst[15:0]}
                                : {{16{fd_inst[15]}}, fd_inst[15:0]};
    // sa field, only low 5 bits used by the alu
    assign shamt = {27'd0, fd_inst[10:6]};

    // control part of decode-to-execute
    always_ff @(posedge clk) begin
        if (!resetn) begin
            de_valid <= 1'b0;
            de_wen   <= 1'b0;
        end else begin
            de_valid <= fd_valid;
            // empty slot enters execute as a bubble
            de_wen   <= fd_valid && dec_wen;
        end
    end

    // payload part
    always_ff @(posedge clk) begin
        de_pc     <= fd_pc;
        de_alu_op <= alu_op;
        de_a      <= a_is_shamt ? shamt : rs_value;
        de_b      <= b_is_imm ? imm : rt_value;
        de_waddr  <= dec_waddr;
    end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                resetn,
    // from decode
    input  logic                de_valid,
    input  mips_pkg::word_t     de_pc,
    input  mips_pkg::alu_op_t   de_alu_op,
    input  mips_pkg::word_t     de_a,
    input  mips_pkg::word_t     de_b,
    input  logic                de_wen,
    input  mips_pkg::reg_addr_t de_waddr,
    // execute-stage bypass
    output logic                ex_wen,
    output mips_pkg::reg_addr_t ex_waddr,
    output mips_pkg::word_t     ex_result,
    // write-back register
    output logic                wb_valid,
    output logic                wb_wen,
    output mips_pkg::reg_addr_t wb_waddr,
    output mips_pkg::word_t     wb_wdata,
    output mips_pkg::word_t     wb_pc
);

    alu alu_inst (
        .op     (de_alu_op),
        .a      (de_a),
        .b      (de_b),
        .result (ex_result)
    );

    // result visible to decode in the same cycle
    assign ex_wen   = de_wen;
    assign ex_waddr = de_waddr;

    // ------------------------------------------------------------
    // execute-to-write-back register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
            wb_wen   <= 1'b0;
        end else begin
            wb_valid <= de_valid;
            wb_wen   <= de_wen;
        end
    end

    always_ff @(posedge clk) begin
        wb_waddr <= de_waddr;
        wb_wdata <= ex_result;
        wb_pc    <= de_pc;
    end

endmodule

`default_nettype wire

/* source/cpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_core #(
    parameter mips_pkg::word_t reset_pc = mips_pkg::reset_vector
) (
    input  logic                clk,
    input  logic                resetn,
    // instruction port
    output logic                inst_req,
    output mips_pkg::word_t     inst_addr,
    input  logic                inst_addr_ok,
    input  logic                inst_data_ok,
    input  mips_pkg::word_t     inst_rdata,
    // debug write-back trace
    output mips_pkg::word_t     debug_wb_pc,
    output logic [3:0]          debug_wb_rf_wen,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t     debug_wb_rf_wdata
);

    logic                fd_valid;
    mips_pkg::word_t     fd_inst;
    mips_pkg::word_t     fd_pc;
    logic                de_valid;
    mips_pkg::word_t     de_pc;
    mips_pkg::alu_op_t   de_alu_op;
    mips_pkg::word_t     de_a;
    mips_pkg::word_t     de_b;
    logic                de_wen;
    mips_pkg::reg_addr_t de_waddr;
    logic                ex_wen;
    mips_pkg::reg_addr_t ex_waddr;
    mips_pkg::word_t     ex_result;
    logic                wb_valid;
    logic                wb_wen;
    mips_pkg::reg_addr_t wb_waddr;
    mips_pkg::word_t     wb_wdata;
    mips_pkg::word_t     wb_pc;

    // ------------------------------------------------------------
    // pipeline stages
    // ------------------------------------------------------------
    fetch_unit #(
        .reset_pc (reset_pc)
    ) fetch_unit_inst (
        .clk          (clk),
        .resetn       (resetn),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .fd_valid     (fd_valid),
        .fd_inst      (fd_inst),
        .fd_pc        (fd_pc)
    );

    decode_stage decode_stage_inst (
        .clk       (clk),
        .resetn    (resetn),
        .fd_valid  (fd_valid),
        .fd_inst   (fd_inst),
        .fd_pc     (fd_pc),
        .de_valid  (de_valid),
        .de_pc     (de_pc),
        .de_alu_op (de_alu_op),
        .de_a      (de_a),
        .de_b      (de_b),
        .de_wen    (de_wen),
        .de_waddr  (de_waddr),
        .ex_wen    (ex_wen),
        .ex_waddr  (ex_waddr),
        .ex_result (ex_result),
        .wb_wen    (wb_wen),
        .wb_waddr  (wb_waddr),
        .wb_wdata  (wb_wdata)
    );

    execute_stage execute_stage_inst (
        .clk       (clk),
        .resetn    (resetn),
        .de_valid  (de_valid),
        .de_pc     (de_pc),
        .de_alu_op (de_alu_op),
        .de_a      (de_a),
        .de_b      (de_b),
        .de_wen    (de_wen),
        .de_waddr  (de_waddr),
        .ex_wen    (ex_wen),
        .ex_waddr  (ex_waddr),
        .ex_result (ex_result),
        .wb_valid  (wb_valid),
        .wb_wen    (wb_wen),
        .wb_waddr  (wb_waddr),
        .wb_wdata  (wb_wdata),
        .wb_pc     (wb_pc)
    );

    // debug trace mirrors the register file write
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{wb_valid && wb_wen}};
    assign debug_wb_rf_wnum  = wb_waddr;
    assign debug_wb_rf_wdata = wb_wdata;

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held low for 8 rising edges, released on an edge
    initial begin
        resetn = 1'b0;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/cpu_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_core_tb;

    localparam int prog_len = 20;

    logic                clk;
    logic                resetn;
    logic                inst_req;
    mips_pkg::word_t     inst_addr;
    logic                inst_addr_ok = 1'b0;
    logic                inst_data_ok = 1'b0;
    mips_pkg::word_t     inst_rdata   = 32'h0;
    mips_pkg::word_t     debug_wb_pc;
    logic [3:0]          debug_wb_rf_wen;
    mips_pkg::reg_addr_t debug_wb_rf_wnum;
    mips_pkg::word_t     debug_wb_rf_wdata;

    // program and expected write-back table
    mips_pkg::word_t     prog    [prog_len];
    logic                exp_wen [prog_len];
    mips_pkg::reg_addr_t exp_reg [prog_len];
    mips_pkg::word_t     exp_val [prog_len];
    int                  n_entries = 0;
    int                  n_writes  = 0;

    // memory model state
    logic [15:0]         lfsr          = 16'd55;
    logic                addr_phase    = 1'b1;
    logic [1:0]          wait_cnt      = 2'd0;
    logic [1:0]          delay         = 2'd0;
    mips_pkg::word_t     pending_word  = 32'h0;
    mips_pkg::word_t     last_addr     = 32'h0;
    logic                first_request = 1'b1;
    int                  data_returns  = 0;

    // debug port monitor state
    int                  cycle       = 0;
    int                  write_total = 0;

    tb_clock_gen clock_gen_inst (
        .clk    (clk),
        .resetn (resetn)
    );

    cpu_core #(
        .reset_pc (mips_pkg::reset_vector)
    ) cpu_core_inst (
        .clk               (clk),
        .resetn            (resetn),
        .inst_req          (inst_req),
        .inst_addr         (inst_addr),
        .inst_addr_ok      (inst_addr_ok),
        .inst_data_ok      (inst_data_ok),
        .inst_rdata        (inst_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    // ------------------------------------------------------------
    // error reporting
    // ------------------------------------------------------------
    task automatic fail_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input mips_pkg::word_t got,
                                   input mips_pkg::word_t expected);
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
        fail_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        fail_run();
    endtask

    // ------------------------------------------------------------
    // encoders and the program table
    // ------------------------------------------------------------
    function automatic mips_pkg::word_t r_type(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [4:0] sa,
                                               input logic [5:0] fn);
        return {mips_pkg::op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic mips_pkg::word_t i_type(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_entry(input mips_pkg::word_t inst, input logic wen,
                             input mips_pkg::reg_addr_t rnum, input mips_pkg::word_t value);
        prog[n_entries]    = inst;
        exp_wen[n_entries] = wen;
        exp_reg[n_entries] = rnum;
        exp_val[n_entries] = value;
        n_entries          = n_entries + 1;
        if (wen) begin
            n_writes = n_writes + 1;
        end
    endtask

    // values worked out by hand with r1 = 12345678 and r2 = ffffffff
    task automatic load_program();
        add_entry(i_type(mips_pkg::op_lui, 5'd0, 5'd1, 16'h1234), 1'b1, 5'd1, 32'h12340000);
        // reads the line above straight from write-back when memory is fast
        add_entry(i_type(mips_pkg::op_ori, 5'd1, 5'd1, 16'h5678), 1'b1, 5'd1, 32'h12345678);
        add_entry(i_type(mips_pkg::op_addiu, 5'd0, 5'd2, 16'hffff), 1'b1, 5'd2, 32'hffffffff);
        add_entry(r_type(5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::fn_addu), 1'b1, 5'd3, 32'h12345677);
        add_entry(r_type(5'd3, 5'd1, 5'd4, 5'd0, mips_pkg::fn_subu), 1'b1, 5'd4, 32'hffffffff);
        add_entry(r_type(5'd1, 5'd2, 5'd5, 5'd0, mips_pkg::fn_and), 1'b1, 5'd5, 32'h12345678);
        add_entry(i_type(mips_pkg::op_andi, 5'd1, 5'd6, 16'h00ff), 1'b1, 5'd6, 32'h00000078);
        add_entry(r_type(5'd1, 5'd6, 5'd7, 5'd0, mips_pkg::fn_xor), 1'b1, 5'd7, 32'h12345600);
        add_entry(r_type(5'd1, 5'd0, 5'd8, 5'd0, mips_pkg::fn_nor), 1'b1, 5'd8, 32'hedcba987);
        // signed compare both ways
        add_entry(r_type(5'd2, 5'd1, 5'd9, 5'd0, mips_pkg::fn_slt), 1'b1, 5'd9, 32'h00000001);
        add_entry(r_type(5'd1, 5'd2, 5'd10, 5'd0, mips_pkg::fn_slt), 1'b1, 5'd10, 32'h0);
        add_entry(r_type(5'd0, 5'd1, 5'd11, 5'd4, mips_pkg::fn_sll), 1'b1, 5'd11, 32'h23456780);
        add_entry(r_type(5'd0, 5'd2, 5'd12, 5'd28, mips_pkg::fn_srl), 1'b1, 5'd12, 32'h0000000f);
        add_entry(i_type(mips_pkg::op_xori, 5'd12, 5'd13, 16'h00f0), 1'b1, 5'd13, 32'h000000ff);
        add_entry(r_type(5'd13, 5'd11, 5'd14, 5'd0, mips_pkg::fn_or), 1'b1, 5'd14, 32'h234567ff);
        // neither the r0 target nor the unknown opcode writes
        add_entry(i_type(mips_pkg::op_addiu, 5'd1, 5'd0, 16'h0005), 1'b0, 5'd0, 32'h0);
        add_entry(32'hfc000000, 1'b0, 5'd0, 32'h0);
        // r0 must still read as zero
        add_entry(r_type(5'd0, 5'd13, 5'd15, 5'd0, mips_pkg::fn_addu), 1'b1, 5'd15, 32'h000000ff);
        add_entry(i_type(mips_pkg::op_addiu, 5'd15, 5'd16, 16'h8001), 1'b1, 5'd16, 32'hffff8100);
        // self dependency back to back
        add_entry(r_type(5'd16, 5'd16, 5'd16, 5'd0, mips_pkg::fn_addu), 1'b1, 5'd16, 32'hffff0200);
    endtask

    // ------------------------------------------------------------
    // instruction memory model
    // ------------------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        // galois form with taps 16 14 13 11
        if (state[0]) begin
            return (state >> 1) ^ 16'hb400;
        end
        return state >> 1;
    endfunction

    // one lfsr step per delay bit
    task automatic draw_delay(output logic [1:0] d);
        d = 2'd0;
        for (int k = 0; k < 2; k++) begin
            lfsr = lfsr_step(lfsr);
            d    = {d[0], lfsr[0]};
        end
    endtask

    function automatic mips_pkg::word_t program_word(input mips_pkg::word_t addr);
        mips_pkg::word_t offset;
        int              idx;
        offset = addr - mips_pkg::reset_vector;
        idx    = int'(offset >> 2);
        // nop past the end
        if (idx < prog_len) begin
            return prog[idx];
        end
        return 32'h0;
    endfunction

    task automatic check_request(input mips_pkg::word_t addr);
        if (first_request) begin
            assert (addr == mips_pkg::reset_vector)
                else report_mismatch("inst_addr", addr, mips_pkg::reset_vector);
        end else begin
            assert (addr == last_addr + 32'd4)
                else report_mismatch("inst_addr", addr, last_addr + 32'd4);
        end
        first_request = 1'b0;
        last_addr     = addr;
    endtask

    // addr_ok and data_ok each come after 0..3 random cycles
    always @(posedge clk) begin
        if (!resetn) begin
            addr_phase   <= 1'b1;
            wait_cnt     <= 2'd0;
            inst_addr_ok <= 1'b0;
            inst_data_ok <= 1'b0;
        end else if (addr_phase) begin
            if (inst_req && inst_addr_ok) begin
                // request accepted on this edge
                check_request(inst_addr);
                pending_word <= program_word(inst_addr);
                inst_addr_ok <= 1'b0;
                addr_phase   <= 1'b0;
                draw_delay(delay);
                if (delay == 2'd0) begin
                    inst_data_ok <= 1'b1;
                    inst_rdata   <= program_word(inst_addr);
                end else begin
                    wait_cnt <= delay - 2'd1;
                end
            end else if (!inst_addr_ok) begin
                if (wait_cnt == 2'd0) begin
                    inst_addr_ok <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end else begin
            if (inst_data_ok) begin
                // word taken on this edge
                inst_data_ok <= 1'b0;
                data_returns <= data_returns + 1;
                addr_phase   <= 1'b1;
                draw_delay(delay);
                if (delay == 2'd0) begin
                    inst_addr_ok <= 1'b1;
                end else begin
                    wait_cnt <= delay - 2'd1;
                end
            end else if (wait_cnt == 2'd0) begin
                inst_data_ok <= 1'b1;
                inst_rdata   <= pending_word;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    // ------------------------------------------------------------
    // debug port monitor and watchdog
    // ------------------------------------------------------------
    always @(posedge clk) begin
        cycle <= cycle + 1;
        // wen quiet once the first edge has applied the reset
        if (!resetn && cycle >= 1) begin
            assert (debug_wb_rf_wen == 4'h0)
                else report_mismatch("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'h0);
        end
        if (resetn && debug_wb_rf_wen != 4'h0) begin
            write_total <= write_total + 1;
        end
    end

    // at most 8 cycles per word plus room for reset and drain
    initial begin
        repeat ((prog_len + 8) * 12) @(posedge clk);
        report_problem("watchdog timeout: the program did not finish in time");
    end

    // ------------------------------------------------------------
    // table walk
    // ------------------------------------------------------------
    initial begin
        mips_pkg::word_t exp_pc;
        load_program();
        while (resetn !== 1'b1) begin
            @(posedge clk);
        end
        for (int i = 0; i < prog_len; i++) begin
            if (exp_wen[i]) begin
                @(posedge clk);
                while (debug_wb_rf_wen == 4'h0) begin
                    @(posedge clk);
                end
                exp_pc = mips_pkg::reset_vector + 32'(i * 4);
                assert (debug_wb_rf_wen == 4'hf)
                    else report_mismatch("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'hf);
                assert (debug_wb_pc == exp_pc)
                    else report_mismatch("debug_wb_pc", debug_wb_pc, exp_pc);
                assert (debug_wb_rf_wnum == exp_reg[i])
                    else report_mismatch("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum),
                                         32'(exp_reg[i]));
                assert (debug_wb_rf_wdata == exp_val[i])
                    else report_mismatch("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val[i]);
            end
        end
        // let a few trailing nops drain through write-back
        while (data_returns < prog_len + 3) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (write_total == n_writes) begin
            $display("Regression passed");
            $finish;
        end else begin
            report_problem("a register write appeared that the program does not make");
        end
    end

endmodule

`default_nettype wire

/* all.f */
source/mips_pkg.sv
source/alu.sv
source/inst_decoder.sv
source/reg_file.sv
source/operand_bypass.sv
source/fetch_unit.sv
source/decode_stage.sv
source/execute_stage.sv
source/cpu_core.sv
testbench/tb_clock_gen.sv
testbench/cpu_core_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run; status follows the pass line in the output
verilator --binary --timing --assert --top-module cpu_core_tb -f all.f -o sim_cpu_core \
    && ./obj_dir/sim_cpu_core | tee /dev/stderr | grep -q "Regression passed" \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation not ok"; exit 1; }
